/* src/rd_cache_pkg.sv */
package rd_cache_pkg;

    // cache geometry
    localparam int unsigned addr_width     = 32;
    localparam int unsigned data_width     = 32;
    localparam int unsigned line_words     = 16;
    localparam int unsigned num_ways       = 4;
    localparam int unsigned tag_width      = $clog2(num_ways);
    localparam int unsigned offset_width   = $clog2(line_words * data_width / 8);
    localparam int unsigned mem_addr_width = tag_width + offset_width - 2;

    typedef enum logic [2:0] {
        dir_none     = 3'd0,
        dir_lookup   = 3'd1,
        dir_allocate = 3'd2,
        dir_update   = 3'd3
    } dir_cmd_e;

    // on an allocate, 3'b010 flags a dirty victim; on a lookup every code but miss is a hit
    typedef enum logic [2:0] {
        st_miss               = 3'b000,
        st_hit_clean          = 3'b001,
        st_alloc_dirty_victim = 3'b010,
        st_hit_dirty          = 3'b011,
        st_hit_owned          = 3'b101,
        st_hit_shared         = 3'b110
    } dir_status_e;

    typedef enum logic [1:0] {
        fetch_writeback = 2'b00,
        fetch_fill      = 2'b01
    } fetch_cmd_e;

    typedef enum logic [3:0] {
        s_idle,
        s_lookup,
        s_wait_mem,
        s_allocate,
        s_wb_req,
        s_wait_wb,
        s_fill_req,
        s_wait_fill,
        s_acc_mem,
        s_update_list
    } rd_state_e;

    typedef struct packed {
        dir_cmd_e               cmd;
        logic [tag_width-1:0]   tag;
        logic [addr_width-1:0]  index;
    } dir_req_t;

    typedef struct packed {
        dir_status_e            status;
        logic [tag_width-1:0]   tag;
        logic [addr_width-1:0]  index;
    } dir_rsp_t;

    typedef struct packed {
        fetch_cmd_e             cmd;
        logic [tag_width-1:0]   tag;
        logic [addr_width-1:0]  addr;
    } fetch_req_t;

endpackage

/* src/rd_seq_fsm.sv */
`timescale 1ns/100ps

module rd_seq_fsm (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       rd_valid,
    output logic                                       rd_ready,
    input  logic [rd_cache_pkg::addr_width-1:0]        rd_addr,
    input  logic                                       dir_gnt,
    input  logic                                       dir_hit,
    input  logic                                       alloc_dirty,
    input  logic [rd_cache_pkg::tag_width-1:0]         way_tag,
    input  logic [rd_cache_pkg::addr_width-1:0]        victim_index,
    input  logic                                       fetch_gnt,
    input  logic                                       fetch_done,
    input  logic                                       mem_read_done,
    output rd_cache_pkg::rd_state_e                    state,
    output logic [rd_cache_pkg::addr_width-1:0]        line_addr,
    output logic [rd_cache_pkg::offset_width-3:0]      word_sel,
    output logic                                       fetch_valid,
    output rd_cache_pkg::fetch_req_t                   fetch_req
);

    import rd_cache_pkg::*;

    rd_state_e             state_next;
    logic                  rd_hsk;
    logic [addr_width-1:0] addr_q;

    assign rd_ready = (state == s_idle);
    assign rd_hsk   = rd_valid && rd_ready;

    // address of the request in flight
    always_ff @(posedge clk) begin
        if (rd_hsk) begin
            addr_q <= rd_addr;
        end
    end

    assign line_addr = {addr_q[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign word_sel  = addr_q[offset_width-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (rd_hsk) begin
                    state_next = s_lookup;
                end
            end
            s_lookup: begin
                if (dir_gnt && dir_hit) begin
                    // read may already go out in the grant cycle
                    state_next = mem_read_done ? s_idle : s_wait_mem;
                end else if (dir_gnt) begin
                    state_next = s_allocate;
                end
            end
            s_wait_mem: begin
                if (mem_read_done) begin
                    state_next = s_idle;
                end
            end
            s_allocate: begin
                if (dir_gnt) begin
                    state_next = alloc_dirty ? s_wb_req : s_fill_req;
                end
            end
            s_wb_req: begin
                if (fetch_gnt) begin
                    state_next = s_wait_wb;
                end
            end
            s_wait_wb: begin
                if (fetch_done) begin
                    state_next = s_fill_req;
                end
            end
            s_fill_req: begin
                if (fetch_gnt) begin
                    state_next = s_wait_fill;
                end
            end
            s_wait_fill: begin
                if (fetch_done) begin
                    state_next = s_acc_mem;
                end
            end
            s_acc_mem: begin
                if (mem_read_done) begin
                    state_next = s_update_list;
                end
            end
            s_update_list: begin
                if (dir_gnt) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    // writeback moves the victim out, fill brings the missing line in
    assign fetch_valid   = (state == s_wb_req) || (state == s_fill_req);
    assign fetch_req.cmd = (state == s_wb_req) ? fetch_writeback : fetch_fill;
    assign fetch_req.tag = way_tag;
    assign fetch_req.addr = (state == s_wb_req) ? victim_index : line_addr;

    a_fetch_valid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_gnt |=> fetch_valid
    );

endmodule

/* src/dir_port.sv */
`timescale 1ns/100ps

module dir_port (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  rd_cache_pkg::rd_state_e                state,
    input  logic [rd_cache_pkg::addr_width-1:0]    line_addr,
    output logic                                   dir_req_valid,
    output rd_cache_pkg::dir_req_t                 dir_req,
    input  logic                                   dir_gnt,
    input  rd_cache_pkg::dir_rsp_t                 dir_rsp,
    output logic                                   dir_hit,
    output logic                                   alloc_dirty,
    output logic [rd_cache_pkg::tag_width-1:0]     way_tag,
    output logic [rd_cache_pkg::addr_width-1:0]    victim_index
);

    import rd_cache_pkg::*;

    logic [tag_width-1:0] tag_q;
    logic                 lookup_gnt;

    always_comb begin
        dir_req_valid = 1'b1;
        dir_req.cmd   = dir_none;
        dir_req.tag   = '0;
        dir_req.index = line_addr;
        case (state)
            s_lookup:      dir_req.cmd = dir_lookup;
            s_allocate:    dir_req.cmd = dir_allocate;
            s_update_list: begin
                dir_req.cmd = dir_update;
                dir_req.tag = tag_q;
            end
            default:       dir_req_valid = 1'b0;
        endcase
    end

    assign dir_hit     = (dir_rsp.status != st_miss);
    assign alloc_dirty = (dir_rsp.status == st_alloc_dirty_victim);
    assign lookup_gnt  = dir_gnt && (state == s_lookup);

    // way comes from a lookup hit or from the allocate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q        <= '0;
            victim_index <= '0;
        end else if (lookup_gnt) begin
            tag_q <= dir_rsp.tag;
        end else if (dir_gnt && state == s_allocate) begin
            tag_q        <= dir_rsp.tag;
            victim_index <= dir_rsp.index;
        end
    end

    // live tag lets the hit read issue in the grant cycle
    assign way_tag = lookup_gnt ? dir_rsp.tag : tag_q;

    a_no_empty_cmd: assert property (
        @(posedge clk) disable iff (!rst_n)
        dir_req_valid |-> dir_req.cmd != dir_none
    );

endmodule

/* src/mem_rd_port.sv */
`timescale 1ns/100ps

module mem_rd_port (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  rd_cache_pkg::rd_state_e                    state,
    input  logic                                       dir_gnt,
    input  logic                                       dir_hit,
    input  logic [rd_cache_pkg::tag_width-1:0]         way_tag,
    input  logic [rd_cache_pkg::offset_width-3:0]      word_sel,
    output logic                                       mem_ren,
    output logic [rd_cache_pkg::mem_addr_width-1:0]    mem_raddr,
    input  logic                                       mem_rready,
    input  logic                                       buf_full,
    output logic                                       mem_read_done,
    output logic                                       rd_done
);

    import rd_cache_pkg::*;

    logic rd_want;

    // hit in the grant cycle, retried hit, or read after a fill
    assign rd_want = (state == s_lookup && dir_gnt && dir_hit) ||
                     (state == s_wait_mem) ||
                     (state == s_acc_mem);

    // no new read while a word is still held
    assign mem_ren       = rd_want && !buf_full;
    assign mem_raddr     = {way_tag, word_sel};
    assign mem_read_done = mem_ren && mem_rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= mem_read_done;
        end
    end

    a_no_read_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        buf_full |-> !mem_ren
    );

endmodule

/* src/rd_data_buf.sv */
`timescale 1ns/100ps

module rd_data_buf (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [rd_cache_pkg::data_width-1:0]    mem_rdata,
    input  logic                                   mem_rdata_valid,
    output logic [rd_cache_pkg::data_width-1:0]    rd_data,
    output logic                                   rd_data_valid,
    input  logic                                   rd_data_ready,
    output logic                                   buf_full
);

    import rd_cache_pkg::*;

    logic                  hold_valid;
    logic [data_width-1:0] hold_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (mem_rdata_valid && !rd_data_ready) begin
            hold_valid <= 1'b1;
        end else if (hold_valid && rd_data_ready) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rdata_valid && !rd_data_ready) begin
            hold_data <= mem_rdata;
        end
    end

    // held word wins over live data
    assign rd_data       = hold_valid ? hold_data : mem_rdata;
    assign rd_data_valid = hold_valid || mem_rdata_valid;
    assign buf_full      = hold_valid;

    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold_valid && !rd_data_ready |-> !mem_rdata_valid
    );

endmodule

/* src/rd_cache_ctrl.sv */
`timescale 1ns/100ps

module rd_cache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic                                       rd_valid,
    output logic                                       rd_ready,
    input  logic [rd_cache_pkg::addr_width-1:0]        rd_addr,
    output logic [rd_cache_pkg::data_width-1:0]        rd_data,
    output logic                                       rd_data_valid,
    input  logic                                       rd_data_ready,
    output logic                                       rd_done,

    output logic                                       dir_req_valid,
    output rd_cache_pkg::dir_req_t                     dir_req,
    input  logic                                       dir_gnt,
    input  rd_cache_pkg::dir_rsp_t                     dir_rsp,

    output logic                                       fetch_valid,
    output rd_cache_pkg::fetch_req_t                   fetch_req,
    input  logic                                       fetch_gnt,
    input  logic                                       fetch_done,

    output logic                                       mem_ren,
    output logic [rd_cache_pkg::mem_addr_width-1:0]    mem_raddr,
    input  logic                                       mem_rready,
    input  logic [rd_cache_pkg::data_width-1:0]        mem_rdata,
    input  logic                                       mem_rdata_valid
);

    import rd_cache_pkg::*;

    rd_state_e               state;
    logic [addr_width-1:0]   line_addr;
    logic [offset_width-3:0] word_sel;
    logic                    dir_hit;
    logic                    alloc_dirty;
    logic [tag_width-1:0]    way_tag;
    logic [addr_width-1:0]   victim_index;
    logic                    mem_read_done;
    logic                    buf_full;

    rd_seq_fsm i_rd_seq_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_addr       (rd_addr),
        .dir_gnt       (dir_gnt),
        .dir_hit       (dir_hit),
        .alloc_dirty   (alloc_dirty),
        .way_tag       (way_tag),
        .victim_index  (victim_index),
        .fetch_gnt     (fetch_gnt),
        .fetch_done    (fetch_done),
        .mem_read_done (mem_read_done),
        .state         (state),
        .line_addr     (line_addr),
        .word_sel      (word_sel),
        .fetch_valid   (fetch_valid),
        .fetch_req     (fetch_req)
    );

    dir_port i_dir_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .line_addr     (line_addr),
        .dir_req_valid (dir_req_valid),
        .dir_req       (dir_req),
        .dir_gnt       (dir_gnt),
        .dir_rsp       (dir_rsp),
        .dir_hit       (dir_hit),
        .alloc_dirty   (alloc_dirty),
        .way_tag       (way_tag),
        .victim_index  (victim_index)
    );

    mem_rd_port i_mem_rd_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .dir_gnt       (dir_gnt),
        .dir_hit       (dir_hit),
        .way_tag       (way_tag),
        .word_sel      (word_sel),
        .mem_ren       (mem_ren),
        .mem_raddr     (mem_raddr),
        .mem_rready    (mem_rready),
        .buf_full      (buf_full),
        .mem_read_done (mem_read_done),
        .rd_done       (rd_done)
    );

    rd_data_buf i_rd_data_buf (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .rd_data         (rd_data),
        .rd_data_valid   (rd_data_valid),
        .rd_data_ready   (rd_data_ready),
        .buf_full        (buf_full)
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    // release away from both clock edges
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        #(period_ns / 4);
        rst_n = 1'b1;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

/* test/tb_rd_cache_ctrl.sv */
`timescale 1ns/100ps

module tb_rd_cache_ctrl;

    import rd_cache_pkg::*;

    typedef enum {
        ex_none, ex_lookup, ex_alloc, ex_wb, ex_wait_wb, ex_fill, ex_wait_fill,
        ex_read_hit, ex_read_miss, ex_update
    } step_e;

    logic                      clk, rst_n;
    logic                      rd_valid, rd_ready, rd_data_valid, rd_data_ready, rd_done;
    logic [addr_width-1:0]     rd_addr;
    logic [data_width-1:0]     rd_data, mem_rdata;
    logic                      dir_req_valid, dir_gnt, fetch_valid, fetch_gnt, fetch_done;
    dir_req_t                  dir_req;
    dir_rsp_t                  dir_rsp;
    fetch_req_t                fetch_req;
    logic                      mem_ren, mem_rready, mem_rdata_valid;
    logic [mem_addr_width-1:0] mem_raddr, pend_addr;

    logic [data_width-1:0]     mem_array [2**mem_addr_width];
    logic [data_width-1:0]     exp_q [$];
    logic [data_width-1:0]     stalled_data;
    logic [addr_width-1:0]     req_addr, req_line, victim;
    logic [tag_width-1:0]      exp_tag;
    logic                      pend_valid, prev_read, stalled, req_taken, fetch_busy;
    step_e                     step;
    integer                    seed = 32'h5c8a;
    int issued, accepted, reads, dones, hits, clean_misses, dirty_misses, stalls;
    int idle_cycles, wait_cycles, fetch_delay;

    tb_clk_gen #(.period_ns(40), .reset_cycles(10)) i_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    rd_cache_ctrl i_rd_cache_ctrl (.*);

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else
            abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
    endtask

    // half the lookups miss, the rest spread over the hit codes
    function automatic dir_status_e lookup_status(input logic [2:0] sel);
        case (sel)
            3'd0:    return st_hit_clean;
            3'd1:    return st_hit_dirty;
            3'd2:    return st_hit_shared;
            3'd3:    return st_hit_owned;
            default: return st_miss;
        endcase
    endfunction

    initial begin
        for (int i = 0; i < 2**mem_addr_width; i++) begin
            mem_array[i] = (i * 32'h0419_2b37) ^ 32'hc0de_5a00;
        end
        rd_valid        = 1'b0;
        rd_addr         = '0;
        rd_data_ready   = 1'b0;
        dir_gnt         = 1'b0;
        dir_rsp         = '0;
        fetch_gnt       = 1'b0;
        fetch_done      = 1'b0;
        mem_rready      = 1'b0;
        mem_rdata       = '0;
        mem_rdata_valid = 1'b0;
        step            = ex_none;
        pend_valid      = 1'b0;
        prev_read       = 1'b0;
        stalled         = 1'b0;
        req_taken       = 1'b0;
        fetch_busy      = 1'b0;

        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            wait_cycles++;
            assert (wait_cycles < 50) else abort_run("reset was never released");
            assert (rd_ready && !dir_req_valid && !fetch_valid && !mem_ren &&
                    !rd_data_valid && !rd_done) else
                abort_run("control outputs are not at their reset values");
        end

        wait_cycles = 0;
        while (!(accepted == 200 && step == ex_none && exp_q.size() == 0)) begin
            @(negedge clk);
            wait_cycles++;
            assert (wait_cycles < 200000) else abort_run("the 200 reads did not complete in time");
        end

        check_value("done pulses reads", accepted, reads);
        check_value("done pulses count", reads, dones);
        assert (hits > 0 && clean_misses > 0 && dirty_misses > 0 && stalls > 0) else
            abort_run("random stimulus missed a hit, a clean miss, a dirty miss or a stall");
        $display("Simulation passed");
        $finish;
    end

    // accelerator, directory, fetcher and memory models
    always @(negedge clk) begin
        if (rst_n) begin
            if (req_taken) begin
                rd_valid  = 1'b0;
                req_taken = 1'b0;
            end
            if (!rd_valid && issued < 200 && ($random(seed) & 3) == 0) begin
                rd_valid = 1'b1;
                rd_addr  = $random(seed);
                issued++;
            end
            dir_rsp.status = lookup_status($random(seed));
            dir_rsp.tag    = $random(seed);
            dir_rsp.index  = $random(seed) & 32'hffff_ffc0;
            dir_gnt        = dir_req_valid && ($random(seed) & 3) == 0;
            if (dir_gnt && dir_req.cmd == dir_allocate) begin
                dir_rsp.status = ($random(seed) & 1) ? st_alloc_dirty_victim : st_miss;
            end
            fetch_gnt  = 1'b0;
            fetch_done = 1'b0;
            if (fetch_busy) begin
                if (fetch_delay == 0) begin
                    fetch_done = 1'b1;
                    fetch_busy = 1'b0;
                end else begin
                    fetch_delay--;
                end
            end else if (fetch_valid && ($random(seed) & 3) == 0) begin
                fetch_gnt   = 1'b1;
                fetch_busy  = 1'b1;
                fetch_delay = $random(seed) & 7;
            end
            mem_rready      = ($random(seed) & 3) != 0;
            mem_rdata_valid = pend_valid;
            mem_rdata       = pend_valid ? mem_array[pend_addr] : $random(seed);
            // consumer mostly stalls over a window of requests
            if (accepted >= 60 && accepted < 90) begin
                rd_data_ready = ($random(seed) & 7) == 0;
            end else begin
                rd_data_ready = ($random(seed) & 3) != 0;
            end
        end
    end

    always @(posedge clk) begin : monitor
        logic read_now;
        if (rst_n) begin
            read_now = mem_ren && mem_rready;
            idle_cycles++;
            check_value("one in flight rd_ready", step == ex_none, rd_ready);
            check_value("dir_req_valid", step inside {ex_lookup, ex_alloc, ex_update},
                        dir_req_valid);
            check_value("fetch_valid", step inside {ex_wb, ex_fill}, fetch_valid);
            check_value("done pulses timing", prev_read, rd_done);
            if (rd_valid && rd_ready) begin
                req_addr    = rd_addr;
                req_line    = rd_addr & 32'hffff_ffc0;
                step        = ex_lookup;
                req_taken   = 1'b1;
                idle_cycles = 0;
                accepted++;
            end
            if (dir_gnt) begin
                idle_cycles = 0;
                case (step)
                    ex_lookup: begin
                        check_value("lookup cmd", dir_lookup, dir_req.cmd);
                        check_value("lookup index", req_line, dir_req.index);
                        exp_tag = dir_rsp.tag;
                        step    = (dir_rsp.status != st_miss) ? ex_read_hit : ex_alloc;
                        hits   += (dir_rsp.status != st_miss);
                    end
                    ex_alloc: begin
                        check_value("clean miss allocate cmd", dir_allocate, dir_req.cmd);
                        check_value("clean miss allocate index", req_line, dir_req.index);
                        exp_tag = dir_rsp.tag;
                        victim  = dir_rsp.index;
                        if (dir_rsp.status == st_alloc_dirty_victim) begin
                            step = ex_wb;
                            dirty_misses++;
                        end else begin
                            step = ex_fill;
                            clean_misses++;
                        end
                    end
                    ex_update: begin
                        check_value("clean miss update cmd", dir_update, dir_req.cmd);
                        check_value("clean miss update tag", exp_tag, dir_req.tag);
                        step = ex_none;
                    end
                    default: abort_run("directory granted while no request was pending");
                endcase
            end
            if (fetch_gnt) begin
                idle_cycles = 0;
                if (step == ex_wb) begin
                    check_value("dirty miss writeback cmd", fetch_writeback, fetch_req.cmd);
                    check_value("dirty miss writeback addr", victim, fetch_req.addr);
                    check_value("dirty miss writeback tag", exp_tag, fetch_req.tag);
                    step = ex_wait_wb;
                end else begin
                    check_value("clean miss fill cmd", fetch_fill, fetch_req.cmd);
                    check_value("clean miss fill addr", req_line, fetch_req.addr);
                    check_value("clean miss fill tag", exp_tag, fetch_req.tag);
                    step = ex_wait_fill;
                end
            end
            if (fetch_done) begin
                step = (step == ex_wait_wb) ? ex_fill : ex_read_miss;
            end
            if (mem_ren) begin
                assert (step inside {ex_read_hit, ex_read_miss}) else
                    abort_run("memory read enabled while no read was pending");
            end
            if (read_now) begin
                idle_cycles = 0;
                check_value("hit data read address", {exp_tag, req_addr[5:2]}, mem_raddr);
                exp_q.push_back(mem_array[{exp_tag, req_addr[5:2]}]);
                reads++;
                step = (step == ex_read_hit) ? ex_none : ex_update;
            end
            if (stalled) begin
                check_value("back-pressure valid", 1'b1, rd_data_valid);
                check_value("back-pressure data", stalled_data, rd_data);
            end
            if (rd_data_valid && rd_data_ready) begin
                assert (exp_q.size() > 0) else
                    abort_run("a data word came out with no memory read behind it");
                check_value("hit data word", exp_q.pop_front(), rd_data);
            end
            stalled      = rd_data_valid && !rd_data_ready;
            stalls      += stalled;
            stalled_data = rd_data;
            prev_read    = read_now;
            pend_valid   = read_now;
            pend_addr    = mem_raddr;
            dones       += rd_done;
            assert (idle_cycles < 2000) else abort_run("the DUT made no progress for 2000 cycles");
        end
    end

endmodule

/* project.f */
src/rd_cache_pkg.sv
src/rd_seq_fsm.sv
src/dir_port.sv
src/mem_rd_port.sv
src/rd_data_buf.sv
src/rd_cache_ctrl.sv
test/tb_clk_gen.sv
test/tb_rd_cache_ctrl.sv

/* Bender.yml */
package:
  name: rd_cache_ctrl

sources:
  - src/rd_cache_pkg.sv
  - src/rd_seq_fsm.sv
  - src/dir_port.sv
  - src/mem_rd_port.sv
  - src/rd_data_buf.sv
  - src/rd_cache_ctrl.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_rd_cache_ctrl.sv
